// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the udma rx testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_udma_rx \
    -f udma_rx.f --Mdir obj_dir -o sim_udma_rx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_udma_rx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// ==== tb/tb_clkgen.sv ====
module tb_clkgen (
    output logic clk_o,
    output logic rstn_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;      // 8 ns period
    end

    initial
    begin
        rstn_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

// ==== tb/tb_udma_rx.sv ====
module tb_udma_rx;

    timeunit 1ns;
    timeprecision 100ps;

    import udma_rx_pkg::*;

    localparam int NUM_CH = 4;

    logic                       clk_i;
    logic                       rstn_i;
    ch_cfg_t     [NUM_CH-1:0]   ch_cfg;
    logic        [NUM_CH-1:0]   ch_en;
    logic        [NUM_CH-1:0]   ch_clr;
    ch_beat_t    [NUM_CH-1:0]   ch_beat;
    logic        [NUM_CH-1:0]   ch_valid;
    logic        [NUM_CH-1:0]   ch_ready;
    logic        [NUM_CH-1:0]   ch_event;
    logic        [NUM_CH-1:0]   ch_active;
    trans_size_t [NUM_CH-1:0]   ch_bytes_left;
    logic                       l2_req;
    logic                       l2_gnt;
    bus_addr_t                  l2_addr;
    l2_be_t                     l2_be;
    word_t                      l2_wdata;

    ch_beat_t    beat_q [NUM_CH][$];     // pending beats per channel
    bus_addr_t   exp_addr_q[$];
    l2_be_t      exp_be_q[$];
    word_t       exp_wdata_q[$];
    string       lines[$];
    int          event_cnt [NUM_CH];
    int          err_addr;
    int          err_be;
    int          err_wdata;
    int          err_event;
    int          err_state;
    int          err_other;
    logic        random_gnt;
    logic [15:0] lfsr;
    logic        lines_loaded;

    tb_clkgen u_clkgen (.clk_o(clk_i), .rstn_o(rstn_i));

    udma_rx_top #(.N_CH(NUM_CH)) DUT (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .ch_cfg_i        (ch_cfg),
        .ch_en_i         (ch_en),
        .ch_clr_i        (ch_clr),
        .ch_beat_i       (ch_beat),
        .ch_valid_i      (ch_valid),
        .ch_ready_o      (ch_ready),
        .ch_event_o      (ch_event),
        .ch_active_o     (ch_active),
        .ch_bytes_left_o (ch_bytes_left),
        .l2_req_o        (l2_req),
        .l2_gnt_i        (l2_gnt),
        .l2_addr_o       (l2_addr),
        .l2_be_o         (l2_be),
        .l2_wdata_o      (l2_wdata)
    );

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hB400;
        return n;
    endfunction

    function automatic int error_total();
        return err_addr + err_be + err_wdata + err_event + err_state + err_other;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_addr(bus_addr_t got, bus_addr_t exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t l2 addr got %h expected %h", $time, got, exp);
            err_addr++;
        end
    endtask

    task automatic check_be(l2_be_t got, l2_be_t exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t l2 be got %h expected %h", $time, got, exp);
            err_be++;
        end
    endtask

    task automatic check_wdata(word_t got, word_t exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t l2 wdata got %h expected %h", $time, got, exp);
            err_wdata++;
        end
    endtask

    task automatic check_event(int ch, int got, int exp);
        if (got != exp)
        begin
            $display("ERR t=%0t ch %0d events got %0d expected %0d", $time, ch, got, exp);
            err_event++;
        end
    endtask

    task automatic check_bytes(int ch, trans_size_t got, trans_size_t exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t ch %0d bytes left got %h expected %h", $time, ch, got, exp);
            err_state++;
        end
    endtask

    task automatic check_active(int ch, logic got, logic exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t ch %0d active got %b expected %b", $time, ch, got, exp);
            err_state++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic configure(int ch, logic [31:0] start, logic [31:0] size, int cont);
        @(negedge clk_i);
        ch_cfg[ch].start_addr = start[15:0];
        ch_cfg[ch].size       = size[15:0];
        ch_cfg[ch].continuous = (cont != 0);
        ch_en[ch]             = 1'b1;
        @(negedge clk_i);
        ch_en[ch] = 1'b0;
    endtask

    task automatic clear_channel(int ch);
        @(negedge clk_i);
        ch_clr[ch] = 1'b1;
        @(negedge clk_i);
        ch_clr[ch] = 1'b0;
    endtask

    // every channel with queued beats keeps valid high until its queue drains
    task automatic run_beats();
        logic [NUM_CH-1:0] took;
        int                pending;
        took    = '0;
        pending = 1;
        while (pending != 0)
        begin
            @(negedge clk_i);
            pending = 0;
            for (int c = 0; c < NUM_CH; c++)
            begin
                if (took[c])
                    void'(beat_q[c].pop_front());
                ch_valid[c] = (beat_q[c].size() > 0);
                if (ch_valid[c])
                begin
                    ch_beat[c] = beat_q[c][0];
                    pending++;
                end
            end
            #3;
            took = ch_valid & ch_ready;
        end
        while (exp_addr_q.size() > 0)
            @(negedge clk_i);
    endtask

    task automatic hold_unready(int ch, ch_beat_t beat, int cycles);
        @(negedge clk_i);
        ch_beat[ch]  = beat;
        ch_valid[ch] = 1'b1;
        repeat (cycles)
        begin
            #3;
            if (ch_ready[ch])
            begin
                $display("channel %0d was ready after it had been cleared", ch);
                err_other++;
            end
            @(negedge clk_i);
        end
        ch_valid[ch] = 1'b0;
    endtask

    task automatic execute_line(string line);
        string       args;
        int          n;
        int          ch;
        int          d0;
        int          d1;
        int          d2;
        logic [31:0] h0;
        logic [31:0] h1;
        ch_beat_t    beat;
        args = line.substr(1, line.len() - 1);
        n    = 0;
        case (line.getc(0))
            "C":
            begin
                n = $sscanf(args, "%d %h %h %d", ch, h0, h1, d0);
                if (n == 4) configure(ch, h0, h1, d0);
            end
            "Q":
            begin
                n = $sscanf(args, "%d %h %d %d", ch, h0, d0, d1);
                beat = '{data: h0, datasize: datasize_t'(d0), dest: dest_t'(d1)};
                if (n == 4) beat_q[ch].push_back(beat);
            end
            "W":
            begin
                n = $sscanf(args, "%h %h %h", h0, h1, d0);
                exp_addr_q.push_back(h0);
                exp_be_q.push_back(h1[3:0]);
                exp_wdata_q.push_back(word_t'(d0));
                n = (n == 3) ? 4 : n;
            end
            "K":
            begin
                n = $sscanf(args, "%d %d %h %d", ch, d0, h0, d1);
                @(negedge clk_i);
                check_active(ch, ch_active[ch], d0[0]);
                check_bytes(ch, ch_bytes_left[ch], h0[15:0]);
                check_event(ch, event_cnt[ch], d1);
                event_cnt[ch] = 0;
            end
            "H":
            begin
                n = $sscanf(args, "%d %h %d %d %d", ch, h0, d0, d1, d2);
                beat = '{data: h0, datasize: datasize_t'(d0), dest: dest_t'(d1)};
                if (n == 5) hold_unready(ch, beat, d2);
                n = (n == 5) ? 4 : 0;
            end
            "G":
            begin
                run_beats();
                n = 4;
            end
            "X":
            begin
                n = $sscanf(args, "%d", ch);
                if (n == 1) clear_channel(ch);
                n = (n == 1) ? 4 : 0;
            end
            "S":
            begin
                n = $sscanf(args, "%d", d0);
                if (n == 1) random_gnt = (d0 != 0);
                n = (n == 1) ? 4 : 0;
            end
            default: n = 0;
        endcase
        if (n != 4)
        begin
            $display("malformed stimulus line: %s", line);
            err_other++;
        end
    endtask

    // grant driver plus write and event monitor
    initial
    begin
        @(posedge rstn_i);
        forever
        begin
            @(negedge clk_i);
            if (random_gnt)
            begin
                l2_gnt = lfsr[0];
                lfsr   = lfsr_step(lfsr);
            end
            else
                l2_gnt = 1'b1;
            #3;
            for (int c = 0; c < NUM_CH; c++)
                if (ch_event[c])
                    event_cnt[c]++;
            if (l2_req && l2_gnt)
            begin
                if (exp_addr_q.size() == 0)
                begin
                    $display("l2 write to %h came with no write expected", l2_addr);
                    err_other++;
                end
                else
                begin
                    check_addr(l2_addr, exp_addr_q.pop_front());
                    check_be(l2_be, exp_be_q.pop_front());
                    check_wdata(l2_wdata, exp_wdata_q.pop_front());
                end
            end
        end
    end

    initial
    begin
        wait (lines_loaded);
        #(200 * 8 * (lines.size() + 10));
        $display("timeout: the stimulus did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        int    fd;
        string line;
        ch_cfg       = '0;
        ch_en        = '0;
        ch_clr       = '0;
        ch_beat      = '0;
        ch_valid     = '0;
        l2_gnt       = 1'b0;
        random_gnt   = 1'b0;
        lfsr         = 16'd6;
        lines_loaded = 1'b0;
        foreach (event_cnt[c])
            event_cnt[c] = 0;
        fd = $fopen("tb/udma_rx_stim.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file tb/udma_rx_stim.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
                lines.push_back(line);
            $fclose(fd);
            lines_loaded = 1'b1;
            @(posedge rstn_i);
            @(negedge clk_i);
            if (l2_req !== 1'b0 || ch_ready !== '0 || ch_event !== '0 || ch_active !== '0)
            begin
                $display("outputs not idle after reset");
                err_other++;
            end
            foreach (lines[i])
                if (lines[i].len() > 1 && lines[i].getc(0) != "#")
                    execute_line(lines[i]);
            $display("errors: addr %0d be %0d wdata %0d event %0d state %0d other %0d",
                     err_addr, err_be, err_wdata, err_event, err_state, err_other);
            if (error_total() == 0)
                $display("Simulation finished: PASS");
            else
                $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

// ==== tb/udma_rx_asserts.sv ====
module udma_rx_asserts #(
    parameter int N_CH = udma_rx_pkg::N_CH
) (
    input logic                   clk_i,
    input logic                   rstn_i,
    input logic [N_CH-1:0]        ch_ready_o,
    input logic [N_CH-1:0]        ch_event_o,
    input logic                   l2_req_o,
    input logic                   l2_gnt_i,
    input udma_rx_pkg::bus_addr_t l2_addr_o,
    input udma_rx_pkg::l2_be_t    l2_be_o,
    input udma_rx_pkg::word_t     l2_wdata_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // a stalled request keeps its payload
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_req_o && !l2_gnt_i |=> l2_req_o && $stable(l2_addr_o) && $stable(l2_be_o)
            && $stable(l2_wdata_o))
        else $error("l2 request dropped or changed before grant");

    a_ready_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(ch_ready_o))
        else $error("more than one channel ready");

    for (genvar i = 0; i < N_CH; i++)
    begin : g_evt
        a_event_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
            ch_event_o[i] |=> !ch_event_o[i])
            else $error("event of channel %0d longer than one cycle", i);
    end

endmodule

bind udma_rx_top udma_rx_asserts #(.N_CH(N_CH)) u_asserts (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .ch_ready_o (ch_ready_o),
    .ch_event_o (ch_event_o),
    .l2_req_o   (l2_req_o),
    .l2_gnt_i   (l2_gnt_i),
    .l2_addr_o  (l2_addr_o),
    .l2_be_o    (l2_be_o),
    .l2_wdata_o (l2_wdata_o)
);

// ==== tb/udma_rx_stim.txt ====
# C ch start size cont | Q ch data size dest | W addr be data | G run queued beats
# K ch active bytes_left events | X ch clear | H ch data size dest cycles | S random grant
K 0 0 0000 0
K 3 0 0000 0
S 0
C 0 0000 0010 0
Q 0 11223344 2 0
Q 0 0000aabb 1 0
Q 0 000000cc 0 0
Q 0 000000dd 0 0
Q 0 55667788 2 0
W 1c000000 f 11223344
W 1c000004 3 0000aabb
W 1c000004 4 00cc0000
W 1c000004 8 dd000000
W 1c000008 f 55667788
G
K 0 1 0004 0
# misaligned halfword and word
C 1 0103 0006 0
Q 1 0000beef 1 0
Q 1 12345678 2 0
W 1c000100 8 ef000000
W 1c000104 1 000000be
W 1c000104 e 34567800
W 1c000108 1 00000012
G
K 1 0 0000 1
# destinations and continuous reload
C 2 0040 0008 1
Q 2 cafef00d 2 1
W 1a100040 f cafef00d
G
K 2 1 0004 0
Q 2 0000abcd 1 2
Q 2 00001234 1 2
W 10000044 3 0000abcd
W 10000044 c 12340000
G
K 2 1 0008 1
Q 2 0badf00d 2 0
W 1c000040 f 0badf00d
G
K 2 1 0004 0
# two channels under random grant stalls
S 1
C 3 0200 0010 0
C 0 0300 0010 0
Q 3 33000001 2 0
Q 3 33000002 2 0
Q 3 33000003 2 0
Q 3 33000004 2 0
Q 0 00000a01 2 0
Q 0 00000a02 2 0
Q 0 00000a03 2 0
Q 0 00000a04 2 0
W 1c000200 f 33000001
W 1c000300 f 00000a01
W 1c000204 f 33000002
W 1c000304 f 00000a02
W 1c000208 f 33000003
W 1c000308 f 00000a03
W 1c00020c f 33000004
W 1c00030c f 00000a04
G
K 3 0 0000 1
K 0 0 0000 1
# clear mid transfer
S 0
C 1 0500 0010 0
Q 1 77777777 2 0
W 1c000500 f 77777777
G
K 1 1 000c 0
X 1
K 1 0 0000 0
H 1 88888888 2 0 10

// ==== udma_rx.f ====
verilog/udma_rx_pkg.sv
verilog/udma_rx_arbiter.sv
verilog/udma_rx_ch_addrgen.sv
verilog/udma_rx_l2_fifo.sv
verilog/udma_rx_l2_writer.sv
verilog/udma_rx_top.sv
tb/tb_clkgen.sv
tb/udma_rx_asserts.sv
tb/tb_udma_rx.sv

// ==== verilog/udma_rx_arbiter.sv ====
module udma_rx_arbiter #(
    parameter int N_CH = udma_rx_pkg::N_CH
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic [N_CH-1:0] req_i,
    input  logic            ack_i,
    output logic [N_CH-1:0] grant_o,
    output logic            any_grant_o
);

    localparam int IDX_W = (N_CH > 1) ? $clog2(N_CH) : 1;

    logic [IDX_W-1:0] ptr_q;        // first channel to look at
    logic [IDX_W-1:0] winner;
    int               cand;

    // search starts at the pointer and wraps around once
    always_comb
    begin
        grant_o     = '0;
        any_grant_o = 1'b0;
        winner      = '0;
        cand        = 0;
        for (int k = 0; k < N_CH; k++)
        begin
            cand = (int'(ptr_q) + k) % N_CH;
            if (!any_grant_o && req_i[cand])
            begin
                any_grant_o   = 1'b1;
                grant_o[cand] = 1'b1;
                winner        = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            ptr_q <= '0;
        else if (ack_i && any_grant_o)
            ptr_q <= (winner == IDX_W'(N_CH - 1)) ? '0 : winner + 1'b1;  // skip past winner
    end

endmodule

// ==== verilog/udma_rx_ch_addrgen.sv ====
module udma_rx_ch_addrgen (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  udma_rx_pkg::ch_cfg_t     cfg_i,
    input  logic                     en_i,
    input  logic                     clr_i,
    input  udma_rx_pkg::datasize_t   datasize_i,
    input  logic                     accept_i,
    output udma_rx_pkg::l2_addr_t    curr_addr_o,
    output udma_rx_pkg::trans_size_t bytes_left_o,
    output logic                     active_o,
    output logic                     event_o
);

    import udma_rx_pkg::*;

    l2_addr_t    curr_addr_q;
    trans_size_t bytes_left_q;
    trans_size_t step;
    logic        active_q;
    logic        event_q;
    logic        last_beat;

    always_comb
    begin
        case (datasize_i)
            2'd0:    step = trans_size_t'(1);
            2'd1:    step = trans_size_t'(2);
            default: step = trans_size_t'(4);
        endcase
    end

    assign last_beat = (bytes_left_q <= step);     // sizes are multiples of the beat

    ////////////////////////////////////////////////////////////////////////////
    // transfer state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            curr_addr_q  <= '0;
            bytes_left_q <= '0;
            active_q     <= 1'b0;
            event_q      <= 1'b0;
        end
        else
        begin
            event_q <= 1'b0;
            if (clr_i)
            begin
                active_q     <= 1'b0;          // stop right away
                bytes_left_q <= '0;
            end
            else if (en_i)
            begin
                curr_addr_q  <= cfg_i.start_addr;
                bytes_left_q <= cfg_i.size;
                active_q     <= 1'b1;
            end
            else if (accept_i && active_q)
            begin
                if (last_beat)
                begin
                    event_q <= 1'b1;
                    if (cfg_i.continuous)
                    begin
                        curr_addr_q  <= cfg_i.start_addr;
                        bytes_left_q <= cfg_i.size;
                    end
                    else
                    begin
                        active_q     <= 1'b0;
                        bytes_left_q <= '0;
                    end
                end
                else
                begin
                    curr_addr_q  <= curr_addr_q + step;
                    bytes_left_q <= bytes_left_q - step;
                end
            end
        end
    end

    assign curr_addr_o  = curr_addr_q;
    assign bytes_left_o = bytes_left_q;
    assign active_o     = active_q;
    assign event_o      = event_q;

endmodule

// ==== verilog/udma_rx_l2_fifo.sv ====
module udma_rx_l2_fifo (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   push_i,
    input  udma_rx_pkg::l2_entry_t entry_i,
    output logic                   ready_o,
    output logic                   valid_o,
    output udma_rx_pkg::l2_entry_t entry_o,
    input  logic                   pop_i
);

    import udma_rx_pkg::*;

    l2_entry_t  mem [4];
    logic [1:0] wr_ptr_q;
    logic [1:0] rd_ptr_q;
    logic [2:0] count_q;
    logic       do_push;
    logic       do_pop;

    assign ready_o = (count_q != 3'd4);
    assign valid_o = (count_q != 3'd0);
    assign entry_o = mem[rd_ptr_q];

    assign do_push = push_i && ready_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk_i)
    begin
        if (do_push)
            mem[wr_ptr_q] <= entry_i;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 2'd1;       // wraps at four
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 2'd1;
            count_q <= count_q + {2'b00, do_push} - {2'b00, do_pop};
        end
    end

endmodule

// ==== verilog/udma_rx_l2_writer.sv ====
module udma_rx_l2_writer (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  udma_rx_pkg::l2_entry_t entry_i,
    input  logic                   valid_i,
    output logic                   pop_o,
    output logic                   l2_req_o,
    input  logic                   l2_gnt_i,
    output udma_rx_pkg::bus_addr_t l2_addr_o,
    output udma_rx_pkg::l2_be_t    l2_be_o,
    output udma_rx_pkg::word_t     l2_wdata_o
);

    import udma_rx_pkg::*;

    wr_state_t   state_q;
    wr_state_t   state_d;
    logic [1:0]  offset;
    logic        misaligned;
    logic [3:0]  size_mask;
    logic [7:0]  be_wide;           // lanes of this word and the next one
    logic [63:0] data_wide;
    logic [13:0] word_addr;

    assign offset = entry_i.addr[1:0];

    always_comb
    begin
        misaligned = 1'b0;
        size_mask  = 4'b0000;
        case (entry_i.datasize)
            2'd0: size_mask = 4'b0001;
            2'd1:
            begin
                size_mask  = 4'b0011;
                misaligned = (offset == 2'd3);
            end
            2'd2:
            begin
                size_mask  = 4'b1111;
                misaligned = (offset != 2'd0);
            end
            default: size_mask = 4'b0000;
        endcase
    end

    assign be_wide   = {4'b0000, size_mask} << offset;
    assign data_wide = {32'h0, entry_i.data} << {offset, 3'b000};

    ////////////////////////////////////////////////////////////////////////////
    // first access covers the addressed word, second the overflow lanes
    ////////////////////////////////////////////////////////////////////////////

    assign l2_req_o   = valid_i;
    assign l2_be_o    = (state_q == WR_SECOND) ? be_wide[7:4] : be_wide[3:0];
    assign l2_wdata_o = (state_q == WR_SECOND) ? data_wide[63:32] : data_wide[31:0];
    assign word_addr  = entry_i.addr[15:2] + {13'd0, state_q == WR_SECOND};

    always_comb
    begin
        l2_addr_o = {16'h0000, word_addr, 2'b00};
        case (entry_i.dest)
            2'd1:    l2_addr_o[31:20] = DEST_PREFIX_1;
            2'd2:    l2_addr_o[31:24] = DEST_PREFIX_2;
            default: l2_addr_o[31:24] = DEST_PREFIX_0;
        endcase
    end

    always_comb
    begin
        state_d = state_q;
        pop_o   = 1'b0;
        case (state_q)
            WR_IDLE:
            begin
                if (valid_i && l2_gnt_i)
                begin
                    if (misaligned)
                        state_d = WR_SECOND;
                    else
                        pop_o = 1'b1;
                end
            end
            WR_SECOND:
            begin
                if (l2_gnt_i)
                begin
                    pop_o   = 1'b1;         // entry done after the overflow write
                    state_d = WR_IDLE;
                end
            end
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            state_q <= WR_IDLE;
        else
            state_q <= state_d;
    end

endmodule

// ==== verilog/udma_rx_pkg.sv ====
package udma_rx_pkg;

    localparam int N_CH = 4;                // linear rx channels

    typedef logic [15:0] l2_addr_t;         // channel address, no memory prefix
    typedef logic [15:0] trans_size_t;      // transfer length in bytes
    typedef logic [1:0]  datasize_t;        // 0 byte, 1 halfword, 2 word
    typedef logic [1:0]  dest_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  l2_be_t;
    typedef logic [31:0] bus_addr_t;

    typedef struct packed {
        l2_addr_t    start_addr;
        trans_size_t size;
        logic        continuous;            // auto reload at end of transfer
    } ch_cfg_t;

    typedef struct packed {
        word_t     data;
        datasize_t datasize;
        dest_t     dest;
    } ch_beat_t;

    typedef struct packed {
        word_t     data;
        l2_addr_t  addr;
        datasize_t datasize;
        dest_t     dest;
    } l2_entry_t;

    typedef enum logic {WR_IDLE, WR_SECOND} wr_state_t;

    // upper address bits per destination, dest 3 falls back to dest 0
    localparam logic [7:0]  DEST_PREFIX_0 = 8'h1C;     // bits 31..24
    localparam logic [11:0] DEST_PREFIX_1 = 12'h1A1;   // bits 31..20
    localparam logic [7:0]  DEST_PREFIX_2 = 8'h10;     // bits 31..24

endpackage

// ==== verilog/udma_rx_top.sv ====
module udma_rx_top #(
    parameter int N_CH = udma_rx_pkg::N_CH
) (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,
    input  udma_rx_pkg::ch_cfg_t     [N_CH-1:0]   ch_cfg_i,
    input  logic                     [N_CH-1:0]   ch_en_i,
    input  logic                     [N_CH-1:0]   ch_clr_i,
    input  udma_rx_pkg::ch_beat_t    [N_CH-1:0]   ch_beat_i,
    input  logic                     [N_CH-1:0]   ch_valid_i,
    output logic                     [N_CH-1:0]   ch_ready_o,
    output logic                     [N_CH-1:0]   ch_event_o,
    output logic                     [N_CH-1:0]   ch_active_o,
    output udma_rx_pkg::trans_size_t [N_CH-1:0]   ch_bytes_left_o,
    output logic                                  l2_req_o,
    input  logic                                  l2_gnt_i,
    output udma_rx_pkg::bus_addr_t                l2_addr_o,
    output udma_rx_pkg::l2_be_t                   l2_be_o,
    output udma_rx_pkg::word_t                    l2_wdata_o
);

    import udma_rx_pkg::*;

    logic      [N_CH-1:0] req;
    logic      [N_CH-1:0] grant;
    logic                 any_grant;
    logic                 fifo_ready;        // doubles as the arbiter acknowledge
    l2_addr_t  [N_CH-1:0] ch_addr;
    ch_beat_t             sel_beat;
    l2_addr_t             sel_addr;
    l2_entry_t            cap_q;
    logic                 cap_valid_q;
    l2_entry_t            fifo_entry;
    logic                 fifo_valid;
    logic                 fifo_pop;

    assign req        = ch_valid_i & ch_active_o;     // idle channels never request
    assign ch_ready_o = grant & {N_CH{fifo_ready}};

    udma_rx_arbiter #(
        .N_CH (N_CH)
    ) u_arbiter (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (req),
        .ack_i       (fifo_ready),
        .grant_o     (grant),
        .any_grant_o (any_grant)
    );

    for (genvar g = 0; g < N_CH; g++)
    begin : g_ch
        udma_rx_ch_addrgen u_addrgen (
            .clk_i        (clk_i),
            .rstn_i       (rstn_i),
            .cfg_i        (ch_cfg_i[g]),
            .en_i         (ch_en_i[g]),
            .clr_i        (ch_clr_i[g]),
            .datasize_i   (ch_beat_i[g].datasize),
            .accept_i     (ch_ready_o[g]),
            .curr_addr_o  (ch_addr[g]),
            .bytes_left_o (ch_bytes_left_o[g]),
            .active_o     (ch_active_o[g]),
            .event_o      (ch_event_o[g])
        );
    end

    always_comb
    begin
        sel_beat = '0;
        sel_addr = '0;
        for (int i = 0; i < N_CH; i++)
        begin
            if (grant[i])
            begin
                sel_beat = ch_beat_i[i];
                sel_addr = ch_addr[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // capture register, loads and pushes only while the fifo has room
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            cap_valid_q <= 1'b0;
        else if (fifo_ready)
            cap_valid_q <= any_grant;
    end

    always_ff @(posedge clk_i)
    begin
        if (fifo_ready && any_grant)
        begin
            cap_q.data     <= sel_beat.data;
            cap_q.addr     <= sel_addr;
            cap_q.datasize <= sel_beat.datasize;
            cap_q.dest     <= sel_beat.dest;
        end
    end

    udma_rx_l2_fifo u_l2_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (cap_valid_q),
        .entry_i (cap_q),
        .ready_o (fifo_ready),
        .valid_o (fifo_valid),
        .entry_o (fifo_entry),
        .pop_i   (fifo_pop)
    );

    udma_rx_l2_writer u_l2_writer (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .entry_i    (fifo_entry),
        .valid_i    (fifo_valid),
        .pop_o      (fifo_pop),
        .l2_req_o   (l2_req_o),
        .l2_gnt_i   (l2_gnt_i),
        .l2_addr_o  (l2_addr_o),
        .l2_be_o    (l2_be_o),
        .l2_wdata_o (l2_wdata_o)
    );

endmodule
